// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cache
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== project.f ====
+incdir+src
src/cache_pkg.sv
src/line_select.sv
src/cache_line.sv
src/cache_ctrl.sv
src/cache_top.sv
verification/tb_cache.sv

// ==== src/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// byte address and data word widths
`define CACHE_ADDR_WIDTH 32
`define CACHE_DATA_WIDTH 32

// 16 lines, 4 words per line
`define CACHE_INDEX_WIDTH 4
`define CACHE_OFFSET_WIDTH 2

// derived sizes
`define CACHE_BYTE_WIDTH $clog2(`CACHE_DATA_WIDTH / 8)
`define CACHE_NUM_LINES (1 << `CACHE_INDEX_WIDTH)
`define CACHE_LINE_WORDS (1 << `CACHE_OFFSET_WIDTH)

`endif

// ==== src/cache_ctrl.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        cpu_req,
    input  logic                        cpu_wr,
    input  size_t                       cpu_size,
    input  addr_t                       cpu_addr,
    input  word_t                       cpu_wdata,
    output logic                        cpu_addr_ok,
    output logic                        cpu_data_ok,
    output word_t                       cpu_rdata,

    input  logic                        hit,
    input  line_status_t                sel_status,
    input  word_t                       sel_word,
    output addr_t                       lookup_addr,
    output offset_t                     rd_offset,
    output logic [`CACHE_NUM_LINES-1:0] line_en,
    output line_wr_t                    line_wr,

    output addr_t                       araddr,
    output logic                        arvalid,
    input  logic                        arready,
    input  word_t                       rdata,
    input  logic                        rlast,
    input  logic                        rvalid,
    output logic                        rready,

    output addr_t                       awaddr,
    output logic                        awvalid,
    input  logic                        awready,
    output mem_w_t                      mem_w,
    output logic                        wvalid,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        bready
);

    ctrl_state_e state;
    cpu_req_t    req_q;
    offset_t     burst_offset;
    offset_t     req_offset;
    index_t      req_index;
    strb_t       req_strb;
    logic        wr_line;

    assign req_offset = addr_offset(req_q.addr);
    assign req_index  = addr_index(req_q.addr);

    // byte enables from size and low address bits, overflow past byte 3 is dropped
    always_comb begin
        case (req_q.size)
            2'd0:    req_strb = strb_t'(4'b0001) << req_q.addr[`CACHE_BYTE_WIDTH-1:0];
            2'd1:    req_strb = strb_t'(4'b0011) << req_q.addr[`CACHE_BYTE_WIDTH-1:0];
            2'd2:    req_strb = strb_t'(4'b0111) << req_q.addr[`CACHE_BYTE_WIDTH-1:0];
            default: req_strb = '1;
        endcase
    end

    // live request while idle, held copy afterwards
    assign lookup_addr = (state == IDLE) ? cpu_addr : req_q.addr;
    assign rd_offset   = (state == WB_W) ? burst_offset : addr_offset(lookup_addr);

    assign cpu_addr_ok = cpu_req && (state == IDLE);
    assign cpu_data_ok = (state == QUERY);
    assign cpu_rdata   = sel_word;

    assign araddr  = {req_q.addr[`CACHE_ADDR_WIDTH-1:`CACHE_BYTE_WIDTH],
                      {`CACHE_BYTE_WIDTH{1'b0}}};
    assign arvalid = (state == FILL_AR);
    assign rready  = (state == FILL_R);

    // victim address, first beat is the word after the requested one
    assign awaddr  = {sel_status.tag, req_index, req_offset, {`CACHE_BYTE_WIDTH{1'b0}}};
    assign awvalid = (state == WB_AW);
    assign wvalid  = (state == WB_W);
    assign bready  = (state == WB_B);

    assign mem_w.data = sel_word;
    assign mem_w.last = (burst_offset == req_offset);

    always_comb begin
        wr_line = 1'b0;
        line_wr = '0;
        case (state)
            QUERY: begin
                if (req_q.wr) begin
                    wr_line        = 1'b1;
                    line_wr.tag    = addr_tag(req_q.addr);
                    line_wr.offset = req_offset;
                    line_wr.data   = req_q.wdata;
                    line_wr.strb   = req_strb;
                    line_wr.dirty  = 1'b1;
                    line_wr.valid  = 1'b1;
                end
            end
            WB_W: begin
                // last beat out, line is clean now
                if (wready && mem_w.last) begin
                    wr_line        = 1'b1;
                    line_wr.tag    = sel_status.tag;
                    line_wr.offset = burst_offset;
                    line_wr.data   = sel_word;
                    line_wr.strb   = '0;
                    line_wr.dirty  = 1'b0;
                    line_wr.valid  = 1'b1;
                end
            end
            FILL_R: begin
                if (rvalid) begin
                    wr_line        = 1'b1;
                    line_wr.tag    = addr_tag(req_q.addr);
                    line_wr.offset = burst_offset;
                    line_wr.data   = rdata;
                    line_wr.strb   = '1;
                    line_wr.dirty  = 1'b0;
                    line_wr.valid  = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
            line_en[i] = wr_line && (req_index == index_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cpu_req) begin
            req_q.wr    <= cpu_wr;
            req_q.size  <= cpu_size;
            req_q.addr  <= cpu_addr;
            req_q.wdata <= cpu_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            burst_offset <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cpu_req) begin
                        if (sel_status.valid && sel_status.dirty && !hit) begin
                            state <= WB_AW;
                        end else if (!hit) begin
                            state <= FILL_AR;
                        end else begin
                            state <= QUERY;
                        end
                    end
                end
                QUERY: begin
                    state <= req_q.wr ? WAIT_WRITE : IDLE;
                end
                WB_AW: begin
                    if (awready) begin
                        burst_offset <= req_offset + offset_t'(1);
                        state        <= WB_W;
                    end
                end
                WB_W: begin
                    // wready assumed to stay high through the burst
                    if (wready) begin
                        burst_offset <= burst_offset + offset_t'(1);
                        if (mem_w.last) begin
                            state <= WB_B;
                        end
                    end
                end
                WB_B: begin
                    if (bvalid) begin
                        state <= FILL_AR;
                    end
                end
                FILL_AR: begin
                    if (arready) begin
                        burst_offset <= req_offset;
                        state        <= FILL_R;
                    end
                end
                FILL_R: begin
                    if (rvalid) begin
                        burst_offset <= burst_offset + offset_t'(1);
                        if (rlast) begin
                            state <= QUERY;
                        end
                    end
                end
                WAIT_WRITE: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // a completed request always ends on a line holding its address
    a_data_ok_hit: assert property (@(posedge clk) disable iff (rst)
        cpu_data_ok |-> hit);

    // victim address held while the write address waits
    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));

endmodule

// ==== src/cache_line.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_line import cache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  line_wr_t     line_wr,
    input  offset_t      rd_offset,
    output line_status_t status,
    output word_t        word
);

    logic  valid_q;
    logic  dirty_q;
    tag_t  tag_q;
    word_t words [`CACHE_LINE_WORDS];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else if (en) begin
            valid_q <= line_wr.valid;
            dirty_q <= line_wr.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            tag_q <= line_wr.tag;
            // only enabled byte lanes change
            for (int b = 0; b < $bits(strb_t); b++) begin
                if (line_wr.strb[b]) begin
                    words[line_wr.offset][8*b +: 8] <= line_wr.data[8*b +: 8];
                end
            end
        end
    end

    assign status.valid = valid_q;
    assign status.dirty = dirty_q;
    assign status.tag   = tag_q;
    assign word         = words[rd_offset];

    a_dirty_implies_valid: assert property (@(posedge clk) disable iff (rst)
        en && line_wr.dirty |-> line_wr.valid);

endmodule

// ==== src/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;
    // address minus index, offset and byte select
    typedef logic [`CACHE_ADDR_WIDTH-`CACHE_INDEX_WIDTH-`CACHE_OFFSET_WIDTH-`CACHE_BYTE_WIDTH-1:0]
        tag_t;
    typedef logic [`CACHE_INDEX_WIDTH-1:0] index_t;
    typedef logic [`CACHE_OFFSET_WIDTH-1:0] offset_t;
    typedef logic [`CACHE_DATA_WIDTH/8-1:0] strb_t;
    typedef logic [1:0] size_t;

    // request held from acceptance to completion
    typedef struct packed {
        logic  wr;
        size_t size;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    // write command broadcast to every line
    typedef struct packed {
        tag_t    tag;
        offset_t offset;
        word_t   data;
        strb_t   strb;
        logic    dirty;
        logic    valid;
    } line_wr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_status_t;

    // one write-back beat
    typedef struct packed {
        word_t data;
        logic  last;
    } mem_w_t;

    typedef enum logic [2:0] {
        IDLE,
        QUERY,
        WB_AW,
        WB_W,
        WB_B,
        FILL_AR,
        FILL_R,
        WAIT_WRITE
    } ctrl_state_e;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[`CACHE_ADDR_WIDTH-1 -: $bits(tag_t)];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[`CACHE_BYTE_WIDTH + `CACHE_OFFSET_WIDTH +: `CACHE_INDEX_WIDTH];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[`CACHE_BYTE_WIDTH +: `CACHE_OFFSET_WIDTH];
    endfunction

endpackage

// ==== src/cache_top.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module cache_top import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,

    input  logic   cpu_req,
    input  logic   cpu_wr,
    input  size_t  cpu_size,
    input  addr_t  cpu_addr,
    input  word_t  cpu_wdata,
    output word_t  cpu_rdata,
    output logic   cpu_addr_ok,
    output logic   cpu_data_ok,

    output addr_t  araddr,
    output logic   arvalid,
    input  logic   arready,
    input  word_t  rdata,
    input  logic   rlast,
    input  logic   rvalid,
    output logic   rready,

    output addr_t  awaddr,
    output logic   awvalid,
    input  logic   awready,
    output mem_w_t mem_w,
    output logic   wvalid,
    input  logic   wready,
    input  logic   bvalid,
    output logic   bready
);

    logic                        hit;
    line_status_t                sel_status;
    word_t                       sel_word;
    addr_t                       lookup_addr;
    offset_t                     rd_offset;
    logic [`CACHE_NUM_LINES-1:0] line_en;
    line_wr_t                    line_wr;
    line_status_t                statuses [`CACHE_NUM_LINES];
    word_t                       words [`CACHE_NUM_LINES];

    cache_ctrl cache_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .cpu_rdata   (cpu_rdata),
        .hit         (hit),
        .sel_status  (sel_status),
        .sel_word    (sel_word),
        .lookup_addr (lookup_addr),
        .rd_offset   (rd_offset),
        .line_en     (line_en),
        .line_wr     (line_wr),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .mem_w       (mem_w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

    for (genvar i = 0; i < `CACHE_NUM_LINES; i++) begin : g_line
        cache_line cache_line_inst (
            .clk       (clk),
            .rst       (rst),
            .en        (line_en[i]),
            .line_wr   (line_wr),
            .rd_offset (rd_offset),
            .status    (statuses[i]),
            .word      (words[i])
        );
    end

    line_select line_select_inst (
        .lookup_addr (lookup_addr),
        .statuses    (statuses),
        .words       (words),
        .sel_status  (sel_status),
        .sel_word    (sel_word),
        .hit         (hit)
    );

endmodule

// ==== src/line_select.sv ====
`timescale 1ns/1ps
`include "cache_cfg.svh"

module line_select import cache_pkg::*; (
    input  addr_t        lookup_addr,
    input  line_status_t statuses [`CACHE_NUM_LINES],
    input  word_t        words [`CACHE_NUM_LINES],
    output line_status_t sel_status,
    output word_t        sel_word,
    output logic         hit
);

    index_t idx;

    assign idx = addr_index(lookup_addr);

    assign sel_status = statuses[idx];
    assign sel_word   = words[idx];

    // valid line with matching tag
    assign hit = sel_status.valid && (sel_status.tag == addr_tag(lookup_addr));

endmodule

// ==== verification/tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache import cache_pkg::*; ();

    // one table row, rdata unused for writes
    typedef struct packed {
        logic  wr;
        size_t size;
        addr_t addr;
        word_t wdata;
        word_t rdata;
        logic  hit;
        logic  evict;
        addr_t wb_addr;
    } stim_t;

    logic   clk;
    logic   rst;
    logic   cpu_req;
    logic   cpu_wr;
    size_t  cpu_size;
    addr_t  cpu_addr;
    word_t  cpu_wdata;
    word_t  cpu_rdata;
    logic   cpu_addr_ok;
    logic   cpu_data_ok;
    addr_t  araddr;
    logic   arvalid;
    logic   arready;
    word_t  rdata;
    logic   rlast;
    logic   rvalid;
    logic   rready;
    addr_t  awaddr;
    logic   awvalid;
    logic   awready;
    mem_w_t mem_w;
    logic   wvalid;
    logic   wready;
    logic   bvalid;
    logic   bready;

    stim_t  stim [$];
    word_t  mem [256];
    word_t  view [256];
    addr_t  ar_addrs [$];
    addr_t  aw_addrs [$];
    word_t  wb_data [$];
    logic   wb_last [$];
    int     cycle = 0;
    int     checks = 0;
    int     value_errors = 0;
    int     other_errors = 0;
    int     last_accept = 0;
    logic   last_write_hit = 1'b0;

    cache_top cache_top_inst (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (cpu_req),
        .cpu_wr      (cpu_wr),
        .cpu_size    (cpu_size),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_rdata   (cpu_rdata),
        .cpu_addr_ok (cpu_addr_ok),
        .cpu_data_ok (cpu_data_ok),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .mem_w       (mem_w),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR %s", msg);
    endtask

    // s+1 bytes from the low address bits, size 3 is the whole word
    function automatic word_t merge_bytes(word_t old, word_t wdata, size_t size,
                                          logic [1:0] lane);
        word_t result;
        int    first;
        int    last;
        result = old;
        first  = (size == 2'd3) ? 0 : int'(lane);
        last   = (size == 2'd3) ? 3 : int'(lane) + int'(size);
        for (int b = 0; b < 4; b++) begin
            if (b >= first && b <= last) begin
                result[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return result;
    endfunction

    // word of a 4-word line, wrapping from the base address
    function automatic logic [7:0] line_word_index(addr_t base, int beat);
        logic [1:0] off;
        off = base[3:2] + 2'(beat);
        return {base[9:4], off};
    endfunction

    task automatic add_entry(input logic wr, input size_t size, input addr_t addr,
                             input word_t wdata, input word_t exp_rdata, input logic hit,
                             input logic evict, input addr_t wb_addr);
        stim_t e;
        e.wr      = wr;
        e.size    = size;
        e.addr    = addr;
        e.wdata   = wdata;
        e.rdata   = exp_rdata;
        e.hit     = hit;
        e.evict   = evict;
        e.wb_addr = wb_addr;
        stim.push_back(e);
    endtask

    task automatic build_table();
        // line 4, tag 0: miss, hits, then strobed writes
        add_entry(1'b0, 2'd2, 32'h0000_0048, 32'h0,         32'h5a5a_0048, 1'b0, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0048, 32'h0,         32'h5a5a_0048, 1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0040, 32'h0,         32'h5a5a_0040, 1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_004c, 32'h0,         32'h5a5a_004c, 1'b1, 1'b0, 32'h0);
        add_entry(1'b1, 2'd0, 32'h0000_0041, 32'hdead_beef, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0040, 32'h0,         32'h5a5a_be40, 1'b1, 1'b0, 32'h0);
        add_entry(1'b1, 2'd1, 32'h0000_0046, 32'h1234_5678, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0044, 32'h0,         32'h1234_0044, 1'b1, 1'b0, 32'h0);
        add_entry(1'b1, 2'd1, 32'h0000_004b, 32'hcafe_f00d, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0048, 32'h0,         32'hca5a_0048, 1'b1, 1'b0, 32'h0);
        add_entry(1'b1, 2'd2, 32'h0000_004d, 32'ha1b2_c3d4, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_004c, 32'h0,         32'ha1b2_c34c, 1'b1, 1'b0, 32'h0);
        add_entry(1'b1, 2'd3, 32'h0000_004e, 32'h8765_4321, 32'h0,         1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_004c, 32'h0,         32'h8765_4321, 1'b1, 1'b0, 32'h0);
        // tag 1 on line 4 evicts the dirty line
        add_entry(1'b0, 2'd2, 32'h0000_0144, 32'h0,         32'h5a5a_0144, 1'b0, 1'b1, 32'h44);
        add_entry(1'b0, 2'd2, 32'h0000_014c, 32'h0,         32'h5a5a_014c, 1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0048, 32'h0,         32'hca5a_0048, 1'b0, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0040, 32'h0,         32'h5a5a_be40, 1'b1, 1'b0, 32'h0);
        // write allocate on line 10, then eviction by tag 3
        add_entry(1'b1, 2'd3, 32'h0000_02a8, 32'h600d_cafe, 32'h0,         1'b0, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_02a8, 32'h0,         32'h600d_cafe, 1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_02a4, 32'h0,         32'h5a5a_02a4, 1'b1, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_03ac, 32'h0,         32'h5a5a_03ac, 1'b0, 1'b1, 32'h2ac);
        add_entry(1'b0, 2'd2, 32'h0000_02a8, 32'h0,         32'h600d_cafe, 1'b0, 1'b0, 32'h0);
        add_entry(1'b1, 2'd0, 32'h0000_0003, 32'h7700_0000, 32'h0,         1'b0, 1'b0, 32'h0);
        add_entry(1'b0, 2'd2, 32'h0000_0000, 32'h0,         32'h775a_0000, 1'b1, 1'b0, 32'h0);
    endtask

    task automatic check_idle_outputs();
        if (arvalid || awvalid || wvalid || rready || bready || cpu_data_ok) begin
            report_problem("bus valid, ready or cpu_data_ok high before the first request");
        end
    endtask

    task automatic run_entry(input stim_t e, input int n);
        int         accept;
        int         lat;
        logic [7:0] widx;
        @(posedge clk);
        #1;
        cpu_req   = 1'b1;
        cpu_wr    = e.wr;
        cpu_size  = e.size;
        cpu_addr  = e.addr;
        cpu_wdata = e.wdata;
        do begin
            @(negedge clk);
            if (cpu_data_ok) begin
                report_problem($sformatf("entry %0d: cpu_data_ok outside a request", n));
            end
        end while (!cpu_addr_ok);
        accept = cycle;
        if (last_write_hit && accept - last_accept != 3) begin
            report_problem($sformatf("entry %0d: accepted %0d cycles after a write hit",
                                     n, accept - last_accept));
        end
        ar_addrs.delete();
        aw_addrs.delete();
        wb_data.delete();
        wb_last.delete();
        // cache holds the request, so the inputs may change now
        @(posedge clk);
        #1;
        cpu_req   = 1'b0;
        cpu_wr    = !e.wr;
        cpu_addr  = ~e.addr;
        cpu_wdata = ~e.wdata;
        do begin
            @(negedge clk);
        end while (!cpu_data_ok);
        lat = cycle - accept;
        if (e.wr) begin
            view[e.addr[9:2]] = merge_bytes(view[e.addr[9:2]], e.wdata, e.size, e.addr[1:0]);
        end else begin
            check_word($sformatf("cpu_rdata (entry %0d)", n), e.rdata, cpu_rdata);
        end
        if (e.hit) begin
            if (lat != 1) begin
                report_problem($sformatf("entry %0d: hit took %0d cycles", n, lat));
            end
            if (ar_addrs.size() != 0 || aw_addrs.size() != 0) begin
                report_problem($sformatf("entry %0d: bus traffic on a hit", n));
            end
        end else if (ar_addrs.size() != 1) begin
            report_problem($sformatf("entry %0d: expected exactly one refill burst", n));
        end else begin
            check_addr($sformatf("araddr (entry %0d)", n), {e.addr[31:2], 2'b00}, ar_addrs[0]);
        end
        if (!e.evict) begin
            if (aw_addrs.size() != 0) begin
                report_problem($sformatf("entry %0d: unexpected write-back", n));
            end
        end else if (aw_addrs.size() != 1 || wb_data.size() != 4) begin
            report_problem($sformatf("entry %0d: write-back burst missing or incomplete", n));
        end else begin
            check_addr($sformatf("awaddr (entry %0d)", n), e.wb_addr, aw_addrs[0]);
            // first beat is the word after awaddr
            for (int k = 0; k < 4; k++) begin
                widx = line_word_index(e.wb_addr, k + 1);
                check_word($sformatf("mem_w.data beat %0d (entry %0d)", k, n),
                           view[widx], wb_data[k]);
                check_flag($sformatf("mem_w.last beat %0d (entry %0d)", k, n),
                           k == 3, wb_last[k]);
            end
        end
        last_accept    = accept;
        last_write_hit = e.wr && e.hit;
    endtask

    // memory model, handshakes sampled at negedge and answered after the next edge
    initial begin : memory_model
        logic   ar_hs, r_hs, aw_hs, w_hs, b_hs;
        logic   ar_v, aw_v;
        addr_t  ar_a, aw_a;
        mem_w_t w_s;
        int     ar_delay, r_delay, aw_delay, w_delay, b_delay;
        int     r_beat, w_beat;
        logic   r_busy, w_busy, b_pending;
        addr_t  r_addr, w_addr;
        void'($urandom(32'he4186bb2));
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata   = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        r_busy    = 1'b0;
        w_busy    = 1'b0;
        b_pending = 1'b0;
        r_beat    = 0;
        w_beat    = 0;
        r_addr    = '0;
        w_addr    = '0;
        r_delay   = 0;
        w_delay   = 0;
        b_delay   = 0;
        ar_delay  = $urandom_range(3, 0);
        aw_delay  = $urandom_range(3, 0);
        forever begin
            @(negedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            b_hs  = bvalid && bready;
            ar_v  = arvalid;
            aw_v  = awvalid;
            ar_a  = araddr;
            aw_a  = awaddr;
            w_s   = mem_w;
            @(posedge clk);
            #1;
            if (ar_hs) begin
                arready = 1'b0;
                ar_addrs.push_back(ar_a);
                r_addr   = ar_a;
                r_beat   = 0;
                r_busy   = 1'b1;
                r_delay  = $urandom_range(3, 0);
                ar_delay = $urandom_range(3, 0);
            end else if (ar_v) begin
                if (ar_delay == 0) arready = 1'b1;
                else ar_delay--;
            end
            if (r_hs) begin
                rvalid  = 1'b0;
                rlast   = 1'b0;
                r_beat++;
                r_delay = $urandom_range(3, 0);
                if (r_beat == 4) r_busy = 1'b0;
            end
            // refill wraps from the requested word
            if (r_busy && !rvalid) begin
                if (r_delay == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem[line_word_index(r_addr, r_beat)];
                    rlast  = (r_beat == 3);
                end else begin
                    r_delay--;
                end
            end
            if (aw_hs) begin
                awready = 1'b0;
                aw_addrs.push_back(aw_a);
                w_addr   = aw_a;
                w_beat   = 0;
                w_busy   = 1'b1;
                w_delay  = $urandom_range(3, 0);
                aw_delay = $urandom_range(3, 0);
            end else if (aw_v) begin
                if (aw_delay == 0) awready = 1'b1;
                else aw_delay--;
            end
            // wready stays high once the burst has started
            if (w_hs) begin
                mem[line_word_index(w_addr, w_beat + 1)] = w_s.data;
                wb_data.push_back(w_s.data);
                wb_last.push_back(w_s.last);
                w_beat++;
                if (w_beat == 4) begin
                    wready    = 1'b0;
                    w_busy    = 1'b0;
                    b_pending = 1'b1;
                    b_delay   = $urandom_range(3, 0);
                end
            end else if (w_busy && !wready) begin
                if (w_delay == 0) wready = 1'b1;
                else w_delay--;
            end
            if (b_hs) bvalid = 1'b0;
            if (b_pending) begin
                if (b_delay == 0) begin
                    bvalid    = 1'b1;
                    b_pending = 1'b0;
                end else begin
                    b_delay--;
                end
            end
        end
    end

    initial begin : stimulus
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_wr    = 1'b0;
        cpu_size  = 2'd0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < 256; i++) begin
            view[i] = word_t'(i * 4) ^ 32'h5a5a_0000;
        end
        build_table();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_idle_outputs();
        end
        for (int n = 0; n < stim.size(); n++) begin
            run_entry(stim[n], n);
        end
        repeat (3) begin
            @(negedge clk);
            if (cpu_data_ok) report_problem("cpu_data_ok after the last request");
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // 200 cycles per table entry
    initial begin : watchdog
        #1;
        repeat (stim.size() * 200) @(posedge clk);
        $display("timeout: requests did not complete in time");
        $display("TEST FAIL");
        $finish;
    end

endmodule
